//--- hw/rv_core_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// machine word, also the instruction width
`define WORD_WIDTH 32

// byte address width of each RAM
`define ADDRESS_WIDTH 16

// register index width
`define REG_ADDRESS_WIDTH 5

// words per RAM, byte address minus the two word-offset bits
`define RAM_WORDS (1 << (`ADDRESS_WIDTH - 2))

`endif

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_system = 7'b1110011
    } opcode_t;

    // branch funct3 encodings
    typedef enum logic [2:0] {
        br_beq  = 3'd0,
        br_bne  = 3'd1,
        br_blt  = 3'd4,
        br_bge  = 3'd5,
        br_bltu = 3'd6,
        br_bgeu = 3'd7
    } branch_cond_t;

    // operations of the execute unit ALU
    typedef enum logic [3:0] {
        alu_none,
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

endpackage

//--- hw/rv_core_pkg.sv
`include "rv_core_settings.svh"

package rv_core_pkg;

    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [`ADDRESS_WIDTH-1:0] address_t;
    typedef logic [`REG_ADDRESS_WIDTH-1:0] reg_index_t;

    // sequencer states
    typedef enum logic [3:0] {
        st_init,
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_registers,
        st_execute,
        st_load,
        st_load_wait,
        st_store,
        st_retire,
        st_halted
    } core_state_t;

endpackage

//--- hw/block_ram.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module block_ram (
    input  logic                      clock,
    input  logic [`ADDRESS_WIDTH-3:0] address,
    input  logic                      write,
    input  rv_core_pkg::word_t        write_data,
    output rv_core_pkg::word_t        read_data
);
    import rv_core_pkg::*;

    word_t memory [`RAM_WORDS];

    // write-first, so a written word shows up on the read port at once
    always_ff @(posedge clock) begin
        if (write) begin
            memory[address] <= write_data;
            read_data <= write_data;
        end else begin
            read_data <= memory[address];
        end
    end

endmodule

//--- hw/register_file.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module register_file (
    input  logic                    clock,
    input  rv_core_pkg::reg_index_t write_index,
    input  logic                    write,
    input  rv_core_pkg::word_t      write_data,
    input  rv_core_pkg::reg_index_t read1_index,
    output rv_core_pkg::word_t      read1_data,
    input  rv_core_pkg::reg_index_t read2_index,
    output rv_core_pkg::word_t      read2_data
);
    import rv_core_pkg::*;

    word_t registers [1 << `REG_ADDRESS_WIDTH];

    always_ff @(posedge clock) begin
        if (write) begin
            registers[write_index] <= write_data;
        end
    end

    // x0 reads as zero whatever its storage holds
    assign read1_data = (read1_index == '0) ? '0 : registers[read1_index];
    assign read2_data = (read2_index == '0) ? '0 : registers[read2_index];

endmodule

//--- hw/instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder (
    input  logic                    clock,
    input  logic                    load,
    input  rv_core_pkg::word_t      instruction,
    output rv_isa_pkg::opcode_t     opcode,
    output rv_core_pkg::reg_index_t rs1,
    output rv_core_pkg::reg_index_t rs2,
    output rv_core_pkg::reg_index_t rd,
    output logic [2:0]              funct3,
    output logic                    funct7_bit,
    output rv_core_pkg::word_t      imm_i,
    output rv_core_pkg::word_t      imm_s,
    output rv_core_pkg::word_t      imm_b,
    output rv_core_pkg::word_t      imm_u,
    output rv_core_pkg::word_t      imm_j
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    word_t inst;
    logic  known;

    // held for the rest of the instruction
    always_ff @(posedge clock) begin
        if (load) begin
            inst <= instruction;
        end
    end

    always_comb begin
        known = 1'b1;
        case (inst[6:0])
            opc_op_imm, opc_op, opc_lui, opc_jal, opc_jalr,
            opc_branch, opc_load, opc_store, opc_system: begin
                opcode = opcode_t'(inst[6:0]);
            end
            default: begin
                // unknown major opcode becomes a system no-op
                opcode = opc_system;
                known = 1'b0;
            end
        endcase
    end

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd = inst[11:7];
    assign funct3 = inst[14:12];
    assign funct7_bit = inst[30];

    // all ones keeps an unknown opcode clear of the ebreak immediate
    assign imm_i = known ? {{20{inst[31]}}, inst[31:20]} : '1;
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

endmodule

//--- hw/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic                clock,
    input  rv_isa_pkg::opcode_t opcode,
    input  logic [2:0]          funct3,
    input  logic                funct7_bit,
    input  rv_core_pkg::word_t  pc,
    input  rv_core_pkg::word_t  rs1_value,
    input  rv_core_pkg::word_t  rs2_value,
    input  rv_core_pkg::word_t  imm_i,
    input  rv_core_pkg::word_t  imm_s,
    input  rv_core_pkg::word_t  imm_b,
    input  rv_core_pkg::word_t  imm_u,
    input  rv_core_pkg::word_t  imm_j,
    output rv_core_pkg::word_t  alu_result,
    output logic                branch_taken
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    word_t   operand1;
    word_t   operand2;
    word_t   result;
    alu_op_t alu_op;
    logic    is_shift;
    logic    taken;

    assign is_shift = (funct3 == 3'd1) || (funct3 == 3'd5);

    // operand selection, address and target sums go through the adder
    always_comb begin
        operand1 = rs1_value;
        operand2 = '0;
        case (opcode)
            opc_op_imm: operand2 = is_shift ? word_t'(imm_i[4:0]) : imm_i;
            opc_op:     operand2 = is_shift ? word_t'(rs2_value[4:0]) : rs2_value;
            opc_jalr,
            opc_load:   operand2 = imm_i;
            opc_store:  operand2 = imm_s;
            opc_lui:    operand1 = imm_u;
            opc_jal: begin
                operand1 = pc;
                operand2 = imm_j;
            end
            opc_branch: begin
                operand1 = pc;
                operand2 = imm_b;
            end
            default:    operand2 = '0;
        endcase
    end

    always_comb begin
        alu_op = alu_add;
        if (opcode == opc_op_imm || opcode == opc_op) begin
            case (funct3)
                // sub only exists in register form
                3'd0:    alu_op = (opcode == opc_op && funct7_bit) ? alu_sub : alu_add;
                3'd1:    alu_op = alu_sll;
                3'd2:    alu_op = alu_slt;
                3'd3:    alu_op = alu_sltu;
                3'd4:    alu_op = alu_xor;
                3'd5:    alu_op = funct7_bit ? alu_sra : alu_srl;
                3'd6:    alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    always_comb begin
        case (alu_op)
            alu_add:  result = operand1 + operand2;
            alu_sub:  result = operand1 - operand2;
            alu_sll:  result = operand1 << operand2[4:0];
            alu_slt:  result = word_t'($signed(operand1) < $signed(operand2));
            alu_sltu: result = word_t'(operand1 < operand2);
            alu_xor:  result = operand1 ^ operand2;
            alu_srl:  result = operand1 >> operand2[4:0];
            alu_sra:  result = $signed(operand1) >>> operand2[4:0];
            alu_or:   result = operand1 | operand2;
            alu_and:  result = operand1 & operand2;
            default:  result = '0;
        endcase
    end

    always_comb begin
        case (branch_cond_t'(funct3))
            br_beq:  taken = (rs1_value == rs2_value);
            br_bne:  taken = (rs1_value != rs2_value);
            br_blt:  taken = ($signed(rs1_value) < $signed(rs2_value));
            br_bge:  taken = ($signed(rs1_value) >= $signed(rs2_value));
            br_bltu: taken = (rs1_value < rs2_value);
            br_bgeu: taken = (rs1_value >= rs2_value);
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        alu_result <= result;
        branch_taken <= taken;
    end

endmodule

//--- hw/control_fsm.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module control_fsm (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      run,
    input  rv_core_pkg::address_t     ext_write_address,
    input  rv_core_pkg::word_t        ext_write_data_word,
    input  logic                      ext_write_inst,
    input  logic                      ext_write_data,
    input  logic                      ext_read_enable,
    output logic                      halted,
    output logic [`ADDRESS_WIDTH-3:0] inst_address,
    output logic                      inst_write,
    output rv_core_pkg::word_t        inst_write_data,
    output logic [`ADDRESS_WIDTH-3:0] data_address,
    output logic                      data_write,
    output rv_core_pkg::word_t        data_write_data,
    input  rv_core_pkg::word_t        inst_read_data,
    input  rv_core_pkg::word_t        data_read_data,
    output logic                      decode_load,
    input  rv_isa_pkg::opcode_t       opcode,
    input  rv_core_pkg::reg_index_t   rd,
    input  rv_core_pkg::word_t        imm_i,
    input  rv_core_pkg::word_t        rs2_value,
    input  rv_core_pkg::word_t        alu_result,
    input  logic                      branch_taken,
    output rv_core_pkg::word_t        pc,
    output logic                      rd_write,
    output rv_core_pkg::reg_index_t   rd_index,
    output rv_core_pkg::word_t        rd_value
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    core_state_t state;
    logic        is_jump;
    logic        writes_rd;

    assign is_jump = (opcode == opc_jal) || (opcode == opc_jalr);
    assign writes_rd = is_jump || opcode == opc_op_imm || opcode == opc_op ||
                       opcode == opc_lui || opcode == opc_load;

    // the RAM word arrives during decode and is captured on its closing edge
    assign decode_load = run && (state == st_decode);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= st_init;
            pc <= '0;
            halted <= 1'b0;
            inst_write <= 1'b0;
            data_write <= 1'b0;
            rd_write <= 1'b0;
        end else if (!run) begin
            // external loading and readback
            inst_write <= ext_write_inst;
            data_write <= ext_write_data;
            if (ext_write_inst) begin
                inst_address <= ext_write_address[`ADDRESS_WIDTH-1:2];
                inst_write_data <= ext_write_data_word;
            end
            if (ext_write_data || ext_read_enable) begin
                data_address <= ext_write_address[`ADDRESS_WIDTH-1:2];
                data_write_data <= ext_write_data_word;
            end
        end else begin
            case (state)
                st_init: begin
                    pc <= '0;
                    state <= st_fetch;
                end
                st_fetch: begin
                    // previous writeback lands on this edge
                    rd_write <= 1'b0;
                    inst_address <= pc[`ADDRESS_WIDTH-1:2];
                    state <= st_fetch_wait;
                end
                st_fetch_wait: state <= st_decode;
                st_decode:     state <= st_registers;
                st_registers: begin
                    // ebreak
                    if (opcode == opc_system && imm_i[11:0] == 12'd1) begin
                        halted <= 1'b1;
                    end
                    state <= st_execute;
                end
                st_execute: begin
                    rd_index <= rd;
                    if (halted) begin
                        state <= st_halted;
                    end else if (opcode == opc_load) begin
                        state <= st_load;
                    end else if (opcode == opc_store) begin
                        state <= st_store;
                    end else begin
                        state <= st_retire;
                    end
                end
                st_load: begin
                    data_address <= alu_result[`ADDRESS_WIDTH-1:2];
                    state <= st_load_wait;
                end
                st_load_wait: state <= st_retire;
                st_store: begin
                    data_address <= alu_result[`ADDRESS_WIDTH-1:2];
                    data_write_data <= rs2_value;
                    data_write <= 1'b1;
                    state <= st_retire;
                end
                st_retire: begin
                    data_write <= 1'b0;
                    rd_write <= writes_rd && (rd_index != '0);
                    if (is_jump) begin
                        rd_value <= pc + 32'd4;
                    end else if (opcode == opc_load) begin
                        rd_value <= data_read_data;
                    end else begin
                        rd_value <= alu_result;
                    end
                    // jalr targets may be odd, bit 0 is dropped
                    if (is_jump) begin
                        pc <= {alu_result[31:1], 1'b0};
                    end else if (opcode == opc_branch && branch_taken) begin
                        pc <= alu_result;
                    end else begin
                        pc <= pc + 32'd4;
                    end
                    state <= st_fetch;
                end
                st_halted: state <= st_halted;
                default:   state <= st_init;
            endcase
        end
    end

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_core (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  run,
    input  rv_core_pkg::address_t ext_write_address,
    input  rv_core_pkg::word_t    ext_write_data_word,
    input  logic                  ext_write_inst,
    input  logic                  ext_write_data,
    input  logic                  ext_read_enable,
    output rv_core_pkg::word_t    ext_read_data,
    output logic                  halted
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    logic [`ADDRESS_WIDTH-3:0] inst_address;
    logic [`ADDRESS_WIDTH-3:0] data_address;
    logic       inst_write;
    logic       data_write;
    word_t      inst_write_data;
    word_t      data_write_data;
    word_t      inst_read_data;
    word_t      data_read_data;
    logic       decode_load;
    opcode_t    opcode;
    reg_index_t rs1;
    reg_index_t rs2;
    reg_index_t rd;
    logic [2:0] funct3;
    logic       funct7_bit;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      rs1_value;
    word_t      rs2_value;
    word_t      alu_result;
    logic       branch_taken;
    word_t      pc;
    logic       rd_write;
    reg_index_t rd_index;
    word_t      rd_value;

    // readback shares the data RAM read port with loads
    assign ext_read_data = data_read_data;

    block_ram inst_ram (
        .clock      (clock),
        .address    (inst_address),
        .write      (inst_write),
        .write_data (inst_write_data),
        .read_data  (inst_read_data)
    );

    block_ram data_ram (
        .clock      (clock),
        .address    (data_address),
        .write      (data_write),
        .write_data (data_write_data),
        .read_data  (data_read_data)
    );

    register_file register_file_i (
        .clock       (clock),
        .write_index (rd_index),
        .write       (rd_write),
        .write_data  (rd_value),
        .read1_index (rs1),
        .read1_data  (rs1_value),
        .read2_index (rs2),
        .read2_data  (rs2_value)
    );

    instruction_decoder instruction_decoder_i (
        .clock       (clock),
        .load        (decode_load),
        .instruction (inst_read_data),
        .opcode      (opcode),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .funct3      (funct3),
        .funct7_bit  (funct7_bit),
        .imm_i       (imm_i),
        .imm_s       (imm_s),
        .imm_b       (imm_b),
        .imm_u       (imm_u),
        .imm_j       (imm_j)
    );

    execute_unit execute_unit_i (
        .clock        (clock),
        .opcode       (opcode),
        .funct3       (funct3),
        .funct7_bit   (funct7_bit),
        .pc           (pc),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .imm_i        (imm_i),
        .imm_s        (imm_s),
        .imm_b        (imm_b),
        .imm_u        (imm_u),
        .imm_j        (imm_j),
        .alu_result   (alu_result),
        .branch_taken (branch_taken)
    );

    control_fsm control_fsm_i (
        .clock               (clock),
        .reset_n             (reset_n),
        .run                 (run),
        .ext_write_address   (ext_write_address),
        .ext_write_data_word (ext_write_data_word),
        .ext_write_inst      (ext_write_inst),
        .ext_write_data      (ext_write_data),
        .ext_read_enable     (ext_read_enable),
        .halted              (halted),
        .inst_address        (inst_address),
        .inst_write          (inst_write),
        .inst_write_data     (inst_write_data),
        .data_address        (data_address),
        .data_write          (data_write),
        .data_write_data     (data_write_data),
        .inst_read_data      (inst_read_data),
        .data_read_data      (data_read_data),
        .decode_load         (decode_load),
        .opcode              (opcode),
        .rd                  (rd),
        .imm_i               (imm_i),
        .rs2_value           (rs2_value),
        .alu_result          (alu_result),
        .branch_taken        (branch_taken),
        .pc                  (pc),
        .rd_write            (rd_write),
        .rd_index            (rd_index),
        .rd_value            (rd_value)
    );

endmodule

//--- testbench/rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions (
    input logic                     clock,
    input logic                     reset_n,
    input logic                     run,
    input logic                     halted,
    input logic                     rd_write,
    input rv_core_pkg::reg_index_t  rd_index,
    input logic                     data_write,
    input rv_core_pkg::core_state_t state
);
    import rv_core_pkg::*;

    // halt is sticky until the next reset
    halted_sticky: assert property (@(posedge clock) disable iff (!reset_n)
        $past(halted) |-> halted)
        else $error("halted fell without a reset");

    // x0 is never a writeback target
    no_x0_write: assert property (@(posedge clock) disable iff (!reset_n)
        rd_write |-> rd_index != '0)
        else $error("register write aimed at x0");

    // during execution the data RAM is only written right after the store state
    store_write_only: assert property (@(posedge clock) disable iff (!reset_n)
        (run && data_write) |-> $past(state == st_store))
        else $error("data RAM write outside a store");

    legal_state: assert property (@(posedge clock) disable iff (!reset_n)
        state <= st_halted)
        else $error("sequencer state outside its legal values");

endmodule

bind control_fsm rv_core_assertions rv_core_assertions_i (
    .clock      (clock),
    .reset_n    (reset_n),
    .run        (run),
    .halted     (halted),
    .rd_write   (rd_write),
    .rd_index   (rd_index),
    .data_write (data_write),
    .state      (state)
);

//--- testbench/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    logic     clock = 1'b0;
    logic     reset_n;
    logic     run;
    address_t ext_write_address;
    word_t    ext_write_data_word;
    logic     ext_write_inst;
    logic     ext_write_data;
    logic     ext_read_enable;
    word_t    ext_read_data;
    logic     halted;

    logic [31:0] lfsr = 32'hcb68a98c;
    word_t       prog[$];
    word_t       expected[$];

    rv_core rv_core_i (
        .clock               (clock),
        .reset_n             (reset_n),
        .run                 (run),
        .ext_write_address   (ext_write_address),
        .ext_write_data_word (ext_write_data_word),
        .ext_write_inst      (ext_write_inst),
        .ext_write_data      (ext_write_data),
        .ext_read_enable     (ext_read_enable),
        .ext_read_data       (ext_read_data),
        .halted              (halted)
    );

    always #5 clock = ~clock;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output word_t w);
        for (int i = 0; i < 32; i++) begin
            lfsr = next_lfsr(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    function automatic word_t enc_i(input opcode_t op, input logic [2:0] f3,
                                    input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic word_t enc_r(input logic [2:0] f3, input logic alt,
                                    input int rd, input int rs1, input int rs2);
        return {1'b0, alt, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], opc_op};
    endfunction

    function automatic word_t enc_s(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'd2, off[4:0], opc_store};
    endfunction

    function automatic word_t enc_b(input branch_cond_t c, input int rs1, input int rs2,
                                    input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], c, off[4:1], off[11], opc_branch};
    endfunction

    function automatic word_t enc_j(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opc_jal};
    endfunction

    // expected ALU result from the RV32I definitions
    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return word_t'($signed(a) < $signed(b));
            3'd3:    return word_t'(a < b);
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input branch_cond_t c, input word_t a, input word_t b);
        case (c)
            br_beq:  return a == b;
            br_bne:  return a != b;
            br_blt:  return $signed(a) < $signed(b);
            br_bge:  return $signed(a) >= $signed(b);
            br_bltu: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic step_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic reset_core();
        reset_n = 1'b0;
        run = 1'b0;
        repeat (8) step_cycle();
        reset_n = 1'b1;
    endtask

    task automatic write_word(input logic to_inst, input address_t addr, input word_t value);
        ext_write_address = addr;
        ext_write_data_word = value;
        ext_write_inst = to_inst;
        ext_write_data = !to_inst;
        step_cycle();
        ext_write_inst = 1'b0;
        ext_write_data = 1'b0;
    endtask

    task automatic read_word(input address_t addr, output word_t value);
        ext_write_address = addr;
        ext_read_enable = 1'b1;
        step_cycle();
        ext_read_enable = 1'b0;
        repeat (3) step_cycle();
        value = ext_read_data;
    endtask

    task automatic check_data(input string name, input address_t addr, input word_t exp);
        word_t value;
        read_word(addr, value);
        check_equal(name, exp, value);
    endtask

    task automatic load_program();
        reset_core();
        foreach (prog[i]) write_word(1'b1, address_t'(i * 4), prog[i]);
    endtask

    task automatic execute_program(input string name);
        int cycles;
        repeat (2) step_cycle();
        check_equal({name, " halted after reset"}, 32'd0, word_t'(halted));
        run = 1'b1;
        for (cycles = 0; cycles < 5000 && !halted; cycles++) step_cycle();
        if (!halted) stop_with_failure({name, ": core did not halt in time"});
        repeat (10) begin
            step_cycle();
            check_equal({name, " halted stays high"}, 32'd1, word_t'(halted));
        end
        run = 1'b0;
        step_cycle();
    endtask

    initial begin
        word_t a;
        word_t b;
        word_t r;
        int    imm;
        int    s;
        int    pairs[3][2] = '{'{1, 2}, '{2, 1}, '{1, 1}};
        branch_cond_t conds[6] = '{br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};
        word_t values[3] = '{32'd0, 32'hfffffffd, 32'd5};
        word_t saved[8];

        reset_n = 1'b0;
        run = 1'b0;
        ext_write_address = '0;
        ext_write_data_word = '0;
        ext_write_inst = 1'b0;
        ext_write_data = 1'b0;
        ext_read_enable = 1'b0;

        // external load and readback with instruction RAM writes to the same addresses
        reset_core();
        foreach (saved[k]) begin
            random_word(saved[k]);
            write_word(1'b0, address_t'(16'h300 + k * 4), saved[k]);
        end
        foreach (saved[k]) write_word(1'b1, address_t'(16'h300 + k * 4), ~saved[k]);
        foreach (saved[k]) begin
            check_data($sformatf("readback %0d", k), address_t'(16'h300 + k * 4), saved[k]);
        end

        // every ALU operation in register and immediate form followed by lui
        random_word(a);
        random_word(b);
        prog = '{enc_i(opc_load, 3'd2, 1, 0, 'h100), enc_i(opc_load, 3'd2, 2, 0, 'h104)};
        expected.delete();
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 1 && f3 != 0 && f3 != 5) continue;
                prog.push_back(enc_r(3'(f3), 1'(alt), 3, 1, 2));
                prog.push_back(enc_s(3, 0, 'h200 + 4 * expected.size()));
                expected.push_back(alu_model(3'(f3), 1'(alt), a, b));
                if (alt == 1 && f3 == 0) continue;
                random_word(r);
                imm = (f3 == 1 || f3 == 5) ? ((alt << 10) | r[4:0]) : int'(r[11:0]);
                prog.push_back(enc_i(opc_op_imm, 3'(f3), 3, 1, imm));
                prog.push_back(enc_s(3, 0, 'h200 + 4 * expected.size()));
                expected.push_back(alu_model(3'(f3), 1'(alt), a, {{20{imm[11]}}, imm[11:0]}));
            end
        end
        random_word(r);
        prog.push_back({r[31:12], 5'd3, opc_lui});
        prog.push_back(enc_s(3, 0, 'h200 + 4 * expected.size()));
        expected.push_back({r[31:12], 12'b0});
        prog.push_back(enc_i(opc_system, 3'd0, 0, 0, 1));
        load_program();
        write_word(1'b0, 16'h100, a);
        write_word(1'b0, 16'h104, b);
        execute_program("alu");
        foreach (expected[k]) begin
            check_data($sformatf("alu %0d", k), address_t'(16'h200 + k * 4), expected[k]);
        end

        // load, modify and store next to untouched neighbours
        random_word(a);
        random_word(b);
        random_word(r);
        prog = '{enc_i(opc_load, 3'd2, 1, 0, 'h400), enc_i(opc_op_imm, 3'd0, 1, 1, 'h123),
                 enc_s(1, 0, 'h410), enc_i(opc_system, 3'd0, 0, 0, 1)};
        load_program();
        write_word(1'b0, 16'h400, a);
        write_word(1'b0, 16'h40c, b);
        write_word(1'b0, 16'h414, r);
        execute_program("memory");
        check_data("memory stored", 16'h410, a + 32'h123);
        check_data("memory source", 16'h400, a);
        check_data("memory below", 16'h40c, b);
        check_data("memory above", 16'h414, r);

        // each branch stores a marker for the path it took
        prog = '{enc_i(opc_op_imm, 3'd0, 1, 0, -3), enc_i(opc_op_imm, 3'd0, 2, 0, 5)};
        expected.delete();
        foreach (conds[c]) begin
            for (int p = 0; p < 3; p++) begin
                prog.push_back(enc_b(conds[c], pairs[p][0], pairs[p][1], 12));
                prog.push_back(enc_i(opc_op_imm, 3'd0, 3, 0, 1));
                prog.push_back(enc_j(0, 8));
                prog.push_back(enc_i(opc_op_imm, 3'd0, 3, 0, 2));
                prog.push_back(enc_s(3, 0, 'h500 + 4 * expected.size()));
                expected.push_back(branch_model(conds[c], values[pairs[p][0]],
                                                values[pairs[p][1]]) ? 32'd2 : 32'd1);
            end
        end
        s = prog.size();
        prog.push_back(enc_j(4, 8));
        prog.push_back(enc_i(opc_op_imm, 3'd0, 4, 0, 99));
        prog.push_back(enc_s(4, 0, 'h500 + 4 * expected.size()));
        expected.push_back(word_t'(s * 4 + 4));
        s = prog.size();
        // odd jalr target whose bit 0 the core drops
        prog.push_back(enc_i(opc_op_imm, 3'd0, 6, 0, (s + 3) * 4 + 1));
        prog.push_back(enc_i(opc_jalr, 3'd0, 7, 6, 0));
        prog.push_back(enc_i(opc_op_imm, 3'd0, 7, 0, 99));
        prog.push_back(enc_s(7, 0, 'h500 + 4 * expected.size()));
        expected.push_back(word_t'((s + 1) * 4 + 4));
        // the link of the next jal shows whether the PC stayed even
        prog.push_back(enc_j(8, 4));
        prog.push_back(enc_s(8, 0, 'h500 + 4 * expected.size()));
        expected.push_back(word_t'((s + 4) * 4 + 4));
        prog.push_back(enc_i(opc_system, 3'd0, 0, 0, 1));
        load_program();
        execute_program("control");
        foreach (expected[k]) begin
            check_data($sformatf("control %0d", k), address_t'(16'h500 + k * 4), expected[k]);
        end

        // x0 stays zero and nothing runs past ebreak
        random_word(a);
        random_word(b);
        prog = '{enc_i(opc_op_imm, 3'd0, 0, 0, 'h55), enc_s(0, 0, 'h600),
                 enc_i(opc_system, 3'd0, 0, 0, 1), enc_s(0, 0, 'h604)};
        load_program();
        write_word(1'b0, 16'h600, a | 32'd1);
        write_word(1'b0, 16'h604, b | 32'd1);
        execute_program("halt");
        check_data("x0 store", 16'h600, 32'd0);
        check_data("after ebreak", 16'h604, b | 32'd1);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- project.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_core_pkg.sv
hw/block_ram.sv
hw/register_file.sv
hw/instruction_decoder.sv
hw/execute_unit.sv
hw/control_fsm.sv
hw/rv_core.sv
testbench/rv_core_assertions.sv
testbench/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb -f project.f -o rv_core_sim

status=0
./obj_dir/rv_core_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
